//--- rtl/core_types_pkg.sv
/*
    core types package
    sizes, vector types and ALU opcodes for the integer execute path
*/

package core_types_pkg;

    // ------------------------------------------------------------------------
    // sizes

    localparam int PR_COUNT           = 64;
    localparam int LOG_PR_COUNT       = 6;
    localparam int PRF_BANK_COUNT     = 4;
    // bank is the low bits of the register number
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int ROB_ENTRIES        = 32;
    localparam int LOG_ROB_ENTRIES    = 5;

    // ------------------------------------------------------------------------
    // vector types

    typedef logic [31:0]                   word_t;
    typedef logic [LOG_PR_COUNT-1:0]       pr_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
    typedef logic [LOG_ROB_ENTRIES-1:0]    rob_idx_t;
    typedef logic [3:0]                    alu_op_t;

    // ------------------------------------------------------------------------
    // ALU opcodes
    // codes not listed here act as pass B

    localparam alu_op_t ALU_ADD   = 4'b0000;
    localparam alu_op_t ALU_SLL   = 4'b0001;
    localparam alu_op_t ALU_SLT   = 4'b0010;
    localparam alu_op_t ALU_SLTU  = 4'b0011;
    localparam alu_op_t ALU_XOR   = 4'b0100;
    localparam alu_op_t ALU_SRL   = 4'b0101;
    localparam alu_op_t ALU_OR    = 4'b0110;
    localparam alu_op_t ALU_AND   = 4'b0111;
    localparam alu_op_t ALU_SUB   = 4'b1000;
    localparam alu_op_t ALU_SRA   = 4'b1101;
    localparam alu_op_t ALU_PASSB = 4'b1111;

endpackage

//--- rtl/prf_read_if.sv
/*
    register file operand read interface
    request, ack with port, bank read data and forward data
*/

`timescale 1ns/1ns

interface prf_read_if;
    import core_types_pkg::*;

    // pulsed once per accepted issue that needs a register read
    logic                                 req_valid;
    pr_t                                  req_pr;

    // ack one cycle after the grant, port says which read port of the bank
    logic                                 ack;
    logic                                 port;
    word_t [PRF_BANK_COUNT-1:0][1:0]      read_data_by_bank_by_port;

    // word being written into each bank this cycle
    word_t [PRF_BANK_COUNT-1:0]           forward_data_by_bank;

    modport pipe (
        output req_valid, req_pr,
        input  ack, port, read_data_by_bank_by_port, forward_data_by_bank
    );

    modport prf (
        input  req_valid, req_pr,
        output ack, port, read_data_by_bank_by_port, forward_data_by_bank
    );

endinterface

//--- rtl/prf_wb_if.sv
/*
    register file writeback interface
    result write from the pipeline, with ready as back-pressure
*/

`timescale 1ns/1ns

interface prf_wb_if;
    import core_types_pkg::*;

    logic     valid;
    word_t    data;
    pr_t      pr;
    rob_idx_t rob_index;

    // low when an external write owns the same bank
    logic     ready;

    modport pipe (output valid, data, pr, rob_index, input ready);
    modport prf  (input valid, data, pr, rob_index, output ready);

endinterface

//--- rtl/alu_imm_pipeline.sv
/*
    ALU register-immediate pipeline
    operand collect, execute and writeback stages with a stall chain
    driven by writeback back-pressure
*/

`timescale 1ns/1ns

module alu_imm_pipeline (
    input  logic                      CLK,
    input  logic                      nRST,

    // issue
    input  logic                      issue_valid,
    input  core_types_pkg::alu_op_t   issue_op,
    input  core_types_pkg::word_t     issue_imm,
    input  logic                      issue_A_unneeded,
    input  logic                      issue_A_forward,
    input  core_types_pkg::pr_t       issue_A_PR,
    input  core_types_pkg::pr_t       issue_dest_PR,
    input  core_types_pkg::rob_idx_t  issue_ROB_index,
    output logic                      issue_ready,

    // register file
    prf_read_if.pipe                  rd,
    prf_wb_if.pipe                    wb
);
    import core_types_pkg::*;

    // stall chain
    logic     stall_wb;
    logic     stall_ex;
    logic     stall_oc;

    // operand collect stage
    logic     valid_oc;
    alu_op_t  op_oc;
    word_t    imm_oc;
    logic     a_unneeded_oc;
    logic     a_forward_oc;
    bank_t    a_bank_oc;
    pr_t      dest_pr_oc;
    rob_idx_t rob_index_oc;
    // A captured while the stage was held
    logic     a_held_oc;
    word_t    a_saved_oc;

    logic     a_present_oc;
    logic     launch_ready_oc;
    word_t    a_collect_oc;

    // execute stage
    logic     valid_ex;
    alu_op_t  op_ex;
    word_t    a_ex;
    word_t    b_ex;
    pr_t      dest_pr_ex;
    rob_idx_t rob_index_ex;
    word_t    alu_result;

    // ------------------------------------------------------------------------
    // stall chain

    assign stall_wb = wb.valid & ~wb.ready;
    assign stall_ex = valid_ex & stall_wb;
    // a bubble in execute lets operand collect move on
    assign stall_oc = stall_ex & valid_oc;

    // ------------------------------------------------------------------------
    // operand collect

    assign a_present_oc = a_unneeded_oc | a_forward_oc | rd.ack | a_held_oc;
    assign launch_ready_oc = ~stall_oc & a_present_oc;
    assign issue_ready = ~valid_oc | launch_ready_oc;

    // read request only for ops that must fetch A from the banks
    assign rd.req_valid = issue_valid & issue_ready & ~issue_A_unneeded & ~issue_A_forward;
    assign rd.req_pr = issue_A_PR;

    always_comb begin
        if (a_held_oc) begin
            a_collect_oc = a_saved_oc;
        end else if (a_forward_oc) begin
            a_collect_oc = rd.forward_data_by_bank[a_bank_oc];
        end else if (a_unneeded_oc) begin
            a_collect_oc = '0;
        end else begin
            a_collect_oc = rd.read_data_by_bank_by_port[a_bank_oc][rd.port];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_oc <= 1'b0;
            a_forward_oc <= 1'b0;
            a_held_oc <= 1'b0;
        end else if (~issue_ready) begin
            // forward data and ack last one cycle, keep what arrived
            a_forward_oc <= 1'b0;
            a_held_oc <= a_present_oc;
        end else begin
            valid_oc <= issue_valid;
            a_forward_oc <= issue_A_forward;
            a_held_oc <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            op_oc <= issue_op;
            imm_oc <= issue_imm;
            a_unneeded_oc <= issue_A_unneeded;
            a_bank_oc <= issue_A_PR[LOG_PRF_BANK_COUNT-1:0];
            dest_pr_oc <= issue_dest_PR;
            rob_index_oc <= issue_ROB_index;
        end else begin
            a_saved_oc <= a_collect_oc;
        end
    end

    // ------------------------------------------------------------------------
    // execute

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_ex <= 1'b0;
        end else if (~stall_ex) begin
            valid_ex <= valid_oc & launch_ready_oc;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_ex) begin
            op_ex <= op_oc;
            a_ex <= a_collect_oc;
            b_ex <= imm_oc;
            dest_pr_ex <= dest_pr_oc;
            rob_index_ex <= rob_index_oc;
        end
    end

    // shifts use the low five bits of B only
    always_comb begin
        case (op_ex)
            ALU_ADD:  alu_result = a_ex + b_ex;
            ALU_SLL:  alu_result = a_ex << b_ex[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(a_ex) < $signed(b_ex)};
            ALU_SLTU: alu_result = {31'b0, a_ex < b_ex};
            ALU_XOR:  alu_result = a_ex ^ b_ex;
            ALU_SRL:  alu_result = a_ex >> b_ex[4:0];
            ALU_OR:   alu_result = a_ex | b_ex;
            ALU_AND:  alu_result = a_ex & b_ex;
            ALU_SUB:  alu_result = a_ex - b_ex;
            ALU_SRA:  alu_result = word_t'($signed(a_ex) >>> b_ex[4:0]);
            default:  alu_result = b_ex;
        endcase
    end

    // ------------------------------------------------------------------------
    // writeback

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            wb.valid <= 1'b0;
            wb.data <= '0;
            wb.pr <= '0;
            wb.rob_index <= '0;
        end else if (~stall_wb) begin
            wb.valid <= valid_ex;
            wb.data <= alu_result;
            wb.pr <= dest_pr_ex;
            wb.rob_index <= rob_index_ex;
        end
    end

endmodule

//--- rtl/banked_prf.sv
/*
    banked physical register file
    four banks with two read ports each, read and write arbitration
    between the ALU pipeline and external ports, per-bank forwarding
*/

`timescale 1ns/1ns

module banked_prf (
    input  logic                          CLK,
    input  logic                          nRST,
    prf_read_if.prf                       rd,
    prf_wb_if.prf                         wb,
    input  logic                          ext_wb_valid,
    input  core_types_pkg::pr_t           ext_wb_pr,
    input  core_types_pkg::word_t         ext_wb_data,
    input  logic [1:0]                    ext_rd_valid,
    input  core_types_pkg::pr_t [1:0]     ext_rd_pr,
    output core_types_pkg::word_t [1:0]   ext_rd_data
);
    import core_types_pkg::*;

    localparam int BANK_DEPTH = PR_COUNT / PRF_BANK_COUNT;
    localparam int ROW_W = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;

    word_t                           mem [PRF_BANK_COUNT][BANK_DEPTH];
    logic [ROW_W-1:0]                row_q [PRF_BANK_COUNT][2];
    logic [ROW_W-1:0]                row_next [PRF_BANK_COUNT][2];
    word_t [PRF_BANK_COUNT-1:0][1:0] bank_rd_data;

    // external reads
    bank_t [1:0]                     ext_bank;
    logic [1:0]                      ext_port;
    bank_t [1:0]                     ext_bank_q;
    logic [1:0]                      ext_port_q;

    // pipeline read, held until a port frees up
    logic                            pend_valid;
    pr_t                             pend_pr;
    logic                            cur_valid;
    pr_t                             cur_pr;
    bank_t                           cur_bank;
    logic                            hit0;
    logic                            hit1;
    logic [1:0]                      busy_ports;
    logic                            grant;

    // writes
    bank_t                           ext_wb_bank;
    bank_t                           pipe_wb_bank;
    logic                            pipe_we;

    // ------------------------------------------------------------------------
    // read arbitration

    assign ext_bank[0] = ext_rd_pr[0][LOG_PRF_BANK_COUNT-1:0];
    assign ext_bank[1] = ext_rd_pr[1][LOG_PRF_BANK_COUNT-1:0];
    assign ext_port[0] = 1'b0;
    assign ext_port[1] = ext_rd_valid[0] & (ext_bank[0] == ext_bank[1]);

    assign cur_valid = rd.req_valid | pend_valid;
    assign cur_pr = rd.req_valid ? rd.req_pr : pend_pr;
    assign cur_bank = cur_pr[LOG_PRF_BANK_COUNT-1:0];

    // external reads take the low ports of the bank first
    assign hit0 = ext_rd_valid[0] & (ext_bank[0] == cur_bank);
    assign hit1 = ext_rd_valid[1] & (ext_bank[1] == cur_bank);
    assign busy_ports = {1'b0, hit0} + {1'b0, hit1};
    assign grant = cur_valid & (busy_ports != 2'd2);

    always_comb begin
        row_next = row_q;
        for (int i = 0; i < 2; i++) begin
            if (ext_rd_valid[i]) begin
                row_next[ext_bank[i]][ext_port[i]] = ext_rd_pr[i][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
            end
        end
        if (grant) begin
            row_next[cur_bank][busy_ports[0]] = cur_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            pend_valid <= 1'b0;
            pend_pr <= '0;
            rd.ack <= 1'b0;
            rd.port <= 1'b0;
            ext_bank_q <= '0;
            ext_port_q <= '0;
        end else begin
            pend_valid <= cur_valid & ~grant;
            pend_pr <= cur_pr;
            rd.ack <= grant;
            rd.port <= busy_ports[0];
            ext_bank_q <= ext_bank;
            ext_port_q <= ext_port;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                row_q[b][0] <= '0;
                row_q[b][1] <= '0;
            end
        end else begin
            row_q <= row_next;
        end
    end

    // read data from the registered row of each port
    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            for (int p = 0; p < 2; p++) begin
                bank_rd_data[b][p] = mem[b][row_q[b][p]];
            end
        end
    end

    assign rd.read_data_by_bank_by_port = bank_rd_data;
    assign ext_rd_data[0] = bank_rd_data[ext_bank_q[0]][ext_port_q[0]];
    assign ext_rd_data[1] = bank_rd_data[ext_bank_q[1]][ext_port_q[1]];

    // ------------------------------------------------------------------------
    // write arbitration and forwarding

    assign ext_wb_bank = ext_wb_pr[LOG_PRF_BANK_COUNT-1:0];
    assign pipe_wb_bank = wb.pr[LOG_PRF_BANK_COUNT-1:0];
    // external write always wins its bank
    assign wb.ready = ~(ext_wb_valid & (ext_wb_bank == pipe_wb_bank));
    assign pipe_we = wb.valid & wb.ready;

    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            if (ext_wb_valid & (ext_wb_bank == bank_t'(b))) begin
                rd.forward_data_by_bank[b] = ext_wb_data;
            end else if (pipe_we & (pipe_wb_bank == bank_t'(b))) begin
                rd.forward_data_by_bank[b] = wb.data;
            end else begin
                rd.forward_data_by_bank[b] = '0;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                for (int r = 0; r < BANK_DEPTH; r++) begin
                    mem[b][r] <= '0;
                end
            end
        end else begin
            if (ext_wb_valid) begin
                mem[ext_wb_bank][ext_wb_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]] <= ext_wb_data;
            end
            if (pipe_we) begin
                mem[pipe_wb_bank][wb.pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]] <= wb.data;
            end
        end
    end

endmodule

//--- rtl/alu_imm_exec_top.sv
/*
    register-immediate execute path top level
    ALU pipeline and banked register file behind plain ports
*/

`timescale 1ns/1ns

module alu_imm_exec_top (
    input  logic                          CLK,
    input  logic                          nRST,

    // issue
    input  logic                          issue_valid,
    input  core_types_pkg::alu_op_t       issue_op,
    input  core_types_pkg::word_t         issue_imm,
    input  logic                          issue_A_unneeded,
    input  logic                          issue_A_forward,
    input  core_types_pkg::pr_t           issue_A_PR,
    input  core_types_pkg::pr_t           issue_dest_PR,
    input  core_types_pkg::rob_idx_t      issue_ROB_index,
    output logic                          issue_ready,

    // sibling pipeline ports
    input  logic                          ext_wb_valid,
    input  core_types_pkg::pr_t           ext_wb_pr,
    input  core_types_pkg::word_t         ext_wb_data,
    input  logic [1:0]                    ext_rd_valid,
    input  core_types_pkg::pr_t [1:0]     ext_rd_pr,
    output core_types_pkg::word_t [1:0]   ext_rd_data,

    // observed writeback
    output logic                          wb_valid,
    output core_types_pkg::word_t         wb_data,
    output core_types_pkg::pr_t           wb_pr,
    output core_types_pkg::rob_idx_t      wb_rob_index,
    output logic                          wb_ready
);

    prf_read_if rd_if ();
    prf_wb_if   wb_if ();

    alu_imm_pipeline u_pipeline (
        .CLK              (CLK),
        .nRST             (nRST),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_imm        (issue_imm),
        .issue_A_unneeded (issue_A_unneeded),
        .issue_A_forward  (issue_A_forward),
        .issue_A_PR       (issue_A_PR),
        .issue_dest_PR    (issue_dest_PR),
        .issue_ROB_index  (issue_ROB_index),
        .issue_ready      (issue_ready),
        .rd               (rd_if.pipe),
        .wb               (wb_if.pipe)
    );

    banked_prf u_prf (
        .CLK              (CLK),
        .nRST             (nRST),
        .rd               (rd_if.prf),
        .wb               (wb_if.prf),
        .ext_wb_valid     (ext_wb_valid),
        .ext_wb_pr        (ext_wb_pr),
        .ext_wb_data      (ext_wb_data),
        .ext_rd_valid     (ext_rd_valid),
        .ext_rd_pr        (ext_rd_pr),
        .ext_rd_data      (ext_rd_data)
    );

    // writeback is visible at the top for checking
    assign wb_valid     = wb_if.valid;
    assign wb_data      = wb_if.data;
    assign wb_pr        = wb_if.pr;
    assign wb_rob_index = wb_if.rob_index;
    assign wb_ready     = wb_if.ready;

endmodule

//--- bench/tb_clock.sv
/*
    testbench clock and reset
    8 ns clock, reset held low for three cycles
*/

`timescale 1ns/1ns

module tb_clock (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

//--- bench/alu_imm_properties.sv
/*
    writeback handshake properties
    bound to the execute path top level
*/

`timescale 1ns/1ns

module alu_imm_properties (
    input logic                      CLK,
    input logic                      nRST,
    input logic                      wb_valid,
    input logic                      wb_ready,
    input core_types_pkg::word_t     wb_data,
    input core_types_pkg::pr_t       wb_pr,
    input core_types_pkg::rob_idx_t  wb_rob_index,
    input logic                      ext_wb_valid,
    input core_types_pkg::pr_t       ext_wb_pr
);
    import core_types_pkg::*;

    // read back by the testbench at the end of the run
    int fail_count = 0;

    // held writeback keeps every field
    wb_hold_stable: assert property (@(posedge CLK) disable iff (!nRST)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data) && $stable(wb_pr)
            && $stable(wb_rob_index))
        else begin
            fail_count++;
            $error("writeback fields changed while held");
        end

    wb_idle_in_reset: assert property (@(posedge CLK) !nRST |-> !wb_valid)
        else begin
            fail_count++;
            $error("wb_valid high during reset");
        end

    // external write owns the bank
    wb_bank_conflict: assert property (@(posedge CLK) disable iff (!nRST)
        ext_wb_valid && wb_valid && (ext_wb_pr[1:0] == wb_pr[1:0]) |-> !wb_ready)
        else begin
            fail_count++;
            $error("pipeline write accepted on a bank taken by the external write");
        end

endmodule

//--- bench/alu_imm_tb.sv
/*
    testbench for the register-immediate execute path
    directed tests, reference model and writeback checker
*/

`timescale 1ns/1ns

module alu_imm_tb;
    import core_types_pkg::*;

    // opcodes, no-read, read conflict, back-pressure and random ops
    localparam int TOTAL_OPS = 13 + 3 + 4 + 1 + 6 + 200;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 2000;

    logic        CLK;
    logic        nRST;
    logic        issue_valid;
    alu_op_t     issue_op;
    word_t       issue_imm;
    logic        issue_A_unneeded;
    logic        issue_A_forward;
    pr_t         issue_A_PR;
    pr_t         issue_dest_PR;
    rob_idx_t    issue_ROB_index;
    logic        issue_ready;
    logic        ext_wb_valid;
    pr_t         ext_wb_pr;
    word_t       ext_wb_data;
    logic [1:0]  ext_rd_valid;
    pr_t [1:0]   ext_rd_pr;
    word_t [1:0] ext_rd_data;
    logic        wb_valid;
    word_t       wb_data;
    pr_t         wb_pr;
    rob_idx_t    wb_rob_index;
    logic        wb_ready;

    // reference model state
    word_t       shadow [PR_COUNT];
    word_t       exp_data [$];
    pr_t         exp_pr [$];
    rob_idx_t    exp_rob [$];
    rob_idx_t    next_rob;
    int          errors;
    logic [31:0] rng;
    logic        saw_stall;

    tb_clock u_clock (.CLK(CLK), .nRST(nRST));

    alu_imm_exec_top DUT (
        .CLK(CLK), .nRST(nRST),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_imm(issue_imm),
        .issue_A_unneeded(issue_A_unneeded), .issue_A_forward(issue_A_forward),
        .issue_A_PR(issue_A_PR), .issue_dest_PR(issue_dest_PR),
        .issue_ROB_index(issue_ROB_index), .issue_ready(issue_ready),
        .ext_wb_valid(ext_wb_valid), .ext_wb_pr(ext_wb_pr), .ext_wb_data(ext_wb_data),
        .ext_rd_valid(ext_rd_valid), .ext_rd_pr(ext_rd_pr), .ext_rd_data(ext_rd_data),
        .wb_valid(wb_valid), .wb_data(wb_data), .wb_pr(wb_pr),
        .wb_rob_index(wb_rob_index), .wb_ready(wb_ready)
    );

    bind alu_imm_exec_top alu_imm_properties u_props (
        .CLK(CLK), .nRST(nRST), .wb_valid(wb_valid), .wb_ready(wb_ready),
        .wb_data(wb_data), .wb_pr(wb_pr), .wb_rob_index(wb_rob_index),
        .ext_wb_valid(ext_wb_valid), .ext_wb_pr(ext_wb_pr)
    );

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ALU rules, shift amount is B mod 32
    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
        int sh;
        sh = int'(b % 32);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return b;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pr(input string name, input pr_t got, input pr_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // drivers, called and returning at a falling edge

    task automatic issue_one(input alu_op_t op, input word_t imm, input logic unneeded,
                             input logic fwd, input pr_t a_pr, input pr_t dest,
                             input word_t a_val);
        issue_valid = 1'b1;
        issue_op = op;
        issue_imm = imm;
        issue_A_unneeded = unneeded;
        issue_A_forward = fwd;
        issue_A_PR = a_pr;
        issue_dest_PR = dest;
        issue_ROB_index = next_rob;
        #1;
        while (!issue_ready) begin
            saw_stall = 1'b1;
            @(negedge CLK);
            #1;
        end
        exp_data.push_back(model_alu(op, unneeded ? 32'd0 : a_val, imm));
        exp_pr.push_back(dest);
        exp_rob.push_back(next_rob);
        next_rob++;
        @(negedge CLK);
        issue_valid = 1'b0;
    endtask

    task automatic ext_write(input pr_t pr, input word_t data);
        ext_wb_valid = 1'b1;
        ext_wb_pr = pr;
        ext_wb_data = data;
        shadow[pr] = data;
        @(negedge CLK);
        ext_wb_valid = 1'b0;
    endtask

    task automatic read_check(input int port, input pr_t pr);
        ext_rd_valid[port] = 1'b1;
        ext_rd_pr[port] = pr;
        @(negedge CLK);
        ext_rd_valid[port] = 1'b0;
        check_word($sformatf("ext_rd_data[%0d] reg %0d", port, pr), ext_rd_data[port],
                   shadow[pr]);
    endtask

    task automatic drain();
        while (exp_data.size() != 0) begin
            @(negedge CLK);
        end
    endtask

    // writeback checker, samples just before the rising edge
    initial begin
        logic     held;
        word_t    held_data;
        pr_t      held_pr;
        rob_idx_t held_rob;
        held = 1'b0;
        wait (nRST);
        forever begin
            @(negedge CLK);
            #2;
            if (held) begin
                check_word("held wb_data", wb_data, held_data);
                check_pr("held wb_pr", wb_pr, held_pr);
                check_rob("held wb_rob_index", wb_rob_index, held_rob);
            end
            held = wb_valid && !wb_ready;
            held_data = wb_data;
            held_pr = wb_pr;
            held_rob = wb_rob_index;
            if (wb_valid && wb_ready) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("writeback to register %0d at %0t with no op outstanding",
                             wb_pr, $time);
                end else begin
                    check_word("wb_data", wb_data, exp_data[0]);
                    check_pr("wb_pr", wb_pr, exp_pr[0]);
                    check_rob("wb_rob_index", wb_rob_index, exp_rob[0]);
                    shadow[exp_pr[0]] = exp_data[0];
                    void'(exp_data.pop_front());
                    void'(exp_pr.pop_front());
                    void'(exp_rob.pop_front());
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // directed tests

    task automatic test_opcodes();
        alu_op_t ops [13];
        word_t   imm;
        ops = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR,
                ALU_AND, ALU_SUB, ALU_SRA, ALU_PASSB, 4'b1001, 4'b1010};
        // negative A for the signed compare and the arithmetic shift
        for (int p = 0; p < 16; p++) begin
            ext_write(pr_t'(p), (p == 2 || p == 9) ? 32'h8000_00f0 : xorshift32());
        end
        for (int i = 0; i < 13; i++) begin
            // shift amounts above 31 on every other op
            imm = (i % 2 == 1) ? 32'd37 + i : xorshift32();
            issue_one(ops[i], imm, 1'b0, 1'b0, pr_t'(i % 16), pr_t'(32 + i),
                      shadow[i % 16]);
        end
        drain();
        for (int i = 0; i < 13; i++) begin
            read_check(i % 2, pr_t'(32 + i));
        end
    endtask

    task automatic test_no_read();
        word_t d;
        for (int k = 0; k < 3; k++) begin
            issue_one(ALU_PASSB, xorshift32(), 1'b1, 1'b0, '0, pr_t'(44 + k), '0);
        end
        drain();
        for (int k = 0; k < 4; k++) begin
            d = xorshift32();
            issue_one(k[0] ? ALU_XOR : ALU_ADD, xorshift32(), 1'b0, 1'b1,
                      pr_t'(20 + k), pr_t'(48 + k), d);
            // source written in the cycle the op sits in operand collect
            ext_write(pr_t'(20 + k), d);
            drain();
        end
    endtask

    task automatic test_read_conflict();
        ext_rd_valid = 2'b11;
        ext_rd_pr[0] = 6'd1;
        ext_rd_pr[1] = 6'd5;
        issue_one(ALU_ADD, 32'h0000_1234, 1'b0, 1'b0, 6'd9, 6'd40, shadow[9]);
        repeat (5) begin
            #1;
            if (issue_ready) begin
                errors++;
                $display("issue_ready high at %0t during read conflict", $time);
            end
            if (wb_valid) begin
                errors++;
                $display("writeback at %0t while the read was blocked", $time);
            end
            @(negedge CLK);
        end
        ext_rd_valid = 2'b00;
        drain();
    endtask

    task automatic test_backpressure();
        saw_stall = 1'b0;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    ext_wb_valid = 1'b1;
                    ext_wb_pr = 6'd18;
                    ext_wb_data = xorshift32();
                    shadow[18] = ext_wb_data;
                    @(negedge CLK);
                end
                ext_wb_valid = 1'b0;
            end
            begin
                for (int k = 0; k < 6; k++) begin
                    issue_one(ALU_SUB, 32'd100 + k, 1'b0, 1'b0, pr_t'(k), pr_t'(34 + 4 * k),
                              shadow[k]);
                end
            end
        join
        drain();
        if (!saw_stall) begin
            errors++;
            $display("issue_ready never fell under writeback back-pressure");
        end
    endtask

    task automatic test_random();
        logic [31:0] r;
        pr_t         a_pr;
        for (int n = 0; n < 200; n++) begin
            r = xorshift32();
            a_pr = pr_t'(r[3:0]);
            ext_wb_valid = r[8];
            ext_wb_pr = pr_t'(16 + r[15:12]);
            ext_wb_data = xorshift32();
            if (r[8]) begin
                shadow[ext_wb_pr] = ext_wb_data;
            end
            // one external read at a time so a pending read always gets through
            ext_rd_valid = r[9] ? (r[10] ? 2'b10 : 2'b01) : 2'b00;
            ext_rd_pr[0] = pr_t'(r[21:16]);
            ext_rd_pr[1] = pr_t'(r[27:22]);
            // sibling traffic lasts one cycle, alongside the issue attempt
            fork
                begin
                    @(negedge CLK);
                    ext_wb_valid = 1'b0;
                    ext_rd_valid = 2'b00;
                end
                begin
                    if (r[30:28] == 3'd0) begin
                        issue_one(ALU_PASSB, xorshift32(), 1'b1, 1'b0, '0,
                                  pr_t'(32 + r[20:16]), '0);
                    end else begin
                        issue_one(alu_op_t'(r[7:4]), xorshift32(), 1'b0, 1'b0, a_pr,
                                  pr_t'(32 + r[20:16]), shadow[a_pr]);
                    end
                end
            join
        end
        drain();
        for (int p = 0; p < PR_COUNT; p++) begin
            read_check(p % 2, pr_t'(p));
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog

    initial begin
        issue_valid = 1'b0;
        issue_op = '0;
        issue_imm = '0;
        issue_A_unneeded = 1'b0;
        issue_A_forward = 1'b0;
        issue_A_PR = '0;
        issue_dest_PR = '0;
        issue_ROB_index = '0;
        ext_wb_valid = 1'b0;
        ext_wb_pr = '0;
        ext_wb_data = '0;
        ext_rd_valid = 2'b00;
        ext_rd_pr = '0;
        errors = 0;
        next_rob = '0;
        rng = 32'h5224;
        saw_stall = 1'b0;
        for (int p = 0; p < PR_COUNT; p++) begin
            shadow[p] = '0;
        end
        wait (nRST);
        @(negedge CLK);
        test_opcodes();
        test_no_read();
        test_read_conflict();
        test_backpressure();
        test_random();
        repeat (4) @(negedge CLK);
        errors += DUT.u_props.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- sources.f
rtl/core_types_pkg.sv
rtl/prf_read_if.sv
rtl/prf_wb_if.sv
rtl/alu_imm_pipeline.sv
rtl/banked_prf.sv
rtl/alu_imm_exec_top.sv
bench/tb_clock.sv
bench/alu_imm_properties.sv
bench/alu_imm_tb.sv

//--- Makefile
# Verilator build for the register-immediate execute path

VERILATOR ?= verilator
TOP       ?= alu_imm_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@! grep -qF "*** FAILED ***" $(LOG)
	@grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
